/* flist.f */
design/raster_cmd_pkg.sv
design/axis_skid_buffer.sv
design/cmd_parser.sv
design/render_control.sv
design/buffer_apply_ctrl.sv
design/cmd_frontend_top.sv
dv/tb_cmd_frontend.sv

/* Bender.yml */
package:
  name: raster_cmd_frontend

sources:
  - target: any(rtl, test)
    files:
      - design/raster_cmd_pkg.sv
  - target: any(rtl, test)
    files:
      - design/axis_skid_buffer.sv
      - design/cmd_parser.sv
      - design/render_control.sv
      - design/buffer_apply_ctrl.sv
      - design/cmd_frontend_top.sv
  - target: test
    files:
      - dv/tb_cmd_frontend.sv

/* dv/tb_cmd_frontend.sv */
// Testbench for the command front end, run from flist.f with tb_cmd_frontend as top
`default_nettype none

module buffer_model (
    input  logic aclk,
    input  logic resetn,
    input  logic apply,
    output logic applied
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [3:0] phase;

    initial
    begin
        applied = 1'b1;
        phase = '0;
    end

    // Busy window opens three cycles after apply and lasts five cycles
    always @(posedge aclk)
    begin
        if (!resetn)
        begin
            applied <= 1'b1;
            phase <= '0;
        end
        else if (phase == 4'd0)
        begin
            if (apply)
                phase <= 4'd1;
        end
        else
        begin
            phase <= (phase == 4'd8) ? 4'd0 : phase + 4'd1;
            if (phase == 4'd3)
                applied <= 1'b0;
            else if (phase == 4'd8)
                applied <= 1'b1;
        end
    end
endmodule

module tb_cmd_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    import raster_cmd_pkg::*;

    typedef enum int {
        st_tri,
        st_tex0,
        st_tex1,
        st_fog,
        st_rcfg
    } stream_e;

    logic       aclk;
    logic       resetn;
    logic       s_cmd_valid;
    logic       s_cmd_ready;
    axis_beat_t s_cmd_beat;
    logic       m_tri_valid, m_tex0_valid, m_tex1_valid, m_fog_valid, m_rcfg_valid;
    logic       m_tri_ready, m_tex0_ready, m_tex1_ready, m_fog_ready, m_rcfg_ready;
    axis_beat_t m_tri_beat, m_tex0_beat, m_tex1_beat, m_fog_beat, m_rcfg_beat;
    logic       rasterizer_running;
    logic       pixel_in_pipeline;
    logic       start_rendering;
    logic       color_applied, depth_applied;
    logic       color_apply, depth_apply;
    logic       buffer_commit, buffer_memset;

    axis_beat_t  exp_q [5][$];
    fb_cmd_t     fb_exp_q [$];
    integer      seed;
    logic [31:0] ready_bits;
    logic        random_ready;
    logic        start_d;
    logic        apply_d;
    int          raster_phase;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_bad;
    int          payload_beats;
    int          tri_cmds;
    int          frame_starts;
    int          cmd_id;

    cmd_frontend_top i_dut (.*);

    buffer_model i_color_buffer (
        .aclk, .resetn, .apply(color_apply), .applied(color_applied)
    );

    buffer_model i_depth_buffer (
        .aclk, .resetn, .apply(depth_apply), .applied(depth_applied)
    );

    initial
    begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // Readies are all high unless the random phase is on
    always @(posedge aclk)
    begin
        ready_bits = $random(seed);
        if (!random_ready)
            ready_bits = '1;
        m_tri_ready <= ready_bits[0];
        m_tex0_ready <= ready_bits[1];
        m_tex1_ready <= ready_bits[2];
        m_fog_ready <= ready_bits[3];
        m_rcfg_ready <= ready_bits[4];
    end

    // Rasterizer runs ten cycles, starting two cycles after the request
    // Pixel pipeline stays busy three cycles past the rasterizer
    always @(posedge aclk)
    begin
        if (!resetn)
        begin
            raster_phase <= 0;
            rasterizer_running <= 1'b0;
            pixel_in_pipeline <= 1'b0;
        end
        else if (raster_phase == 0)
        begin
            if (start_rendering)
                raster_phase <= 1;
        end
        else
        begin
            raster_phase <= (raster_phase == 15) ? 0 : raster_phase + 1;
            if (raster_phase == 2)
                rasterizer_running <= 1'b1;
            else if (raster_phase == 12)
                rasterizer_running <= 1'b0;
            if (raster_phase == 9)
                pixel_in_pipeline <= 1'b1;
            else if (raster_phase == 15)
                pixel_in_pipeline <= 1'b0;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        error_count++;
        $display("Mismatch at %0t ns: %s expected 0x%0h, actual 0x%0h",
                 $time, sig, expected, actual);
    endtask

    task automatic check_beat(input stream_e s, input string sig, input axis_beat_t got);
        axis_beat_t exp;
        assert (exp_q[s].size() != 0)
        else
        begin
            error_count++;
            $display("%0t ns: %s delivered a beat that no command asked for", $time, sig);
        end
        if (exp_q[s].size() != 0)
        begin
            exp = exp_q[s].pop_front();
            assert (got.tdata == exp.tdata)
            else report_mismatch({sig, ".tdata"}, exp.tdata, got.tdata);
            assert (got.tlast == exp.tlast)
            else report_mismatch({sig, ".tlast"}, 32'(exp.tlast), 32'(got.tlast));
            if (s == st_rcfg)
            begin
                assert (got.tuser == exp.tuser)
                else report_mismatch({sig, ".tuser"}, 32'(exp.tuser), 32'(got.tuser));
            end
        end
    endtask

    task automatic check_apply();
        fb_cmd_t    exp;
        logic [3:0] got;
        got = {buffer_commit, buffer_memset, color_apply, depth_apply};
        assert (fb_exp_q.size() != 0)
        else
        begin
            error_count++;
            $display("%0t ns: buffer apply raised with no framebuffer command pending", $time);
        end
        if (fb_exp_q.size() != 0)
        begin
            exp = fb_exp_q.pop_front();
            assert (got == exp)
            else report_mismatch("{buffer_commit,buffer_memset,color_apply,depth_apply}",
                                 32'(exp), 32'(got));
        end
    endtask

    // Values seen here are the ones present before the edge
    always @(posedge aclk)
    begin
        if (resetn)
        begin
            if (m_tri_valid && m_tri_ready)
                check_beat(st_tri, "m_tri_beat", m_tri_beat);
            if (m_tex0_valid && m_tex0_ready)
                check_beat(st_tex0, "m_tex0_beat", m_tex0_beat);
            if (m_tex1_valid && m_tex1_ready)
                check_beat(st_tex1, "m_tex1_beat", m_tex1_beat);
            if (m_fog_valid && m_fog_ready)
                check_beat(st_fog, "m_fog_beat", m_fog_beat);
            if (m_rcfg_valid && m_rcfg_ready)
                check_beat(st_rcfg, "m_rcfg_beat", m_rcfg_beat);
            if (start_rendering && !start_d)
                frame_starts++;
            if ((color_apply || depth_apply) && !apply_d)
                check_apply();
        end
        start_d <= start_rendering;
        apply_d <= color_apply || depth_apply;
    end

    no_accept_while_rendering: assert property (
        @(posedge aclk) disable iff (!resetn)
        (start_rendering || rasterizer_running || pixel_in_pipeline) |-> !s_cmd_ready)
    else
    begin
        error_count++;
        $display("%0t ns: command stream ready while the rasterizer or pixel pipeline is busy",
                 $time);
    end

    no_accept_while_buffers_busy: assert property (
        @(posedge aclk) disable iff (!resetn)
        !(color_applied && depth_applied) |-> !s_cmd_ready)
    else
    begin
        error_count++;
        $display("%0t ns: command stream ready before both buffers reported applied", $time);
    end

    start_held_until_taken: assert property (
        @(posedge aclk) disable iff (!resetn)
        start_rendering && !rasterizer_running |=> start_rendering)
    else
    begin
        error_count++;
        $display("%0t ns: start_rendering dropped before the rasterizer took it", $time);
    end

    task automatic send_word(input logic [31:0] word, input logic last);
        s_cmd_valid <= 1'b1;
        s_cmd_beat <= '{tdata: word, tlast: last, tuser: 4'd0};
        do
            @(posedge aclk);
        while (!s_cmd_ready);
    endtask

    task automatic send_stream_cmd(input logic [31:0] header, input stream_e s,
                                   input int beats, input logic [3:0] user);
        axis_beat_t  exp;
        logic [31:0] word;
        cmd_id++;
        payload_beats += beats;
        send_word(header, beats == 0);
        for (int i = 0; i < beats; i++)
        begin
            word = {cmd_id[7:0], 24'(i)};
            exp = '{tdata: word, tlast: (i == beats - 1), tuser: user};
            exp_q[s].push_back(exp);
            send_word(word, i == beats - 1);
        end
        s_cmd_valid <= 1'b0;
    endtask

    // Payload is the byte count over four
    task automatic send_triangle(input int bytes);
        tri_cmds++;
        send_stream_cmd((32'(op_triangle_stream) << op_pos) | 32'(bytes), st_tri,
                        bytes / 4, 4'd0);
    endtask

    task automatic send_texture(input int log2_size, input logic tmu);
        int beats;
        beats = (log2_size == 0) ? 0 : (1 << (log2_size - 2));
        send_stream_cmd((32'(op_texture_stream) << op_pos) | (32'(tmu) << tex_tmu_pos)
                        | 32'(log2_size), tmu ? st_tex1 : st_tex0, beats, 4'd0);
    endtask

    task automatic send_fog();
        send_stream_cmd(32'(op_fog_lut_stream) << op_pos, st_fog, 33, 4'd0);
    endtask

    task automatic send_render_config(input logic [3:0] index);
        send_stream_cmd((32'(op_render_config) << op_pos) | 32'(index), st_rcfg, 1, index);
    endtask

    task automatic send_framebuffer(input logic commit, input logic memset,
                                    input logic color, input logic depth);
        fb_cmd_t fb;
        fb = '{commit: commit, memset: memset, color_select: color, depth_select: depth};
        if (color || depth)
            fb_exp_q.push_back(fb);
        send_word((32'(op_framebuffer) << op_pos) | (32'(commit) << fb_commit_pos)
                  | (32'(memset) << fb_memset_pos) | (32'(color) << fb_color_pos)
                  | (32'(depth) << fb_depth_pos), 1'b1);
        s_cmd_valid <= 1'b0;
    endtask

    // A nop is only taken once the whole pipeline is idle again
    task automatic send_nop();
        send_word(32'(op_nop) << op_pos, 1'b1);
        s_cmd_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q[st_tri].size() + exp_q[st_tex0].size() + exp_q[st_tex1].size()
               + exp_q[st_fog].size() + exp_q[st_rcfg].size() + fb_exp_q.size() != 0)
            @(posedge aclk);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (error_count == test_errors)
            $display("%0t ns: %s ... ok", $time, name);
        else
        begin
            tests_bad++;
            $display("%0t ns: %s ... %0d error(s)", $time, name, error_count - test_errors);
        end
        test_errors = error_count;
    endtask

    initial
    begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 2000 + 20 * payload_beats)
        begin
            @(posedge aclk);
            cycles++;
        end
        $display("%0t ns: watchdog expired, the DUT stopped responding", $time);
        $display("tests failed");
        $finish;
    end

    initial
    begin
        seed = 32'ha4b2;
        resetn = 1'b0;
        s_cmd_valid = 1'b0;
        s_cmd_beat = '0;
        m_tri_ready = 1'b1;
        m_tex0_ready = 1'b1;
        m_tex1_ready = 1'b1;
        m_fog_ready = 1'b1;
        m_rcfg_ready = 1'b1;
        rasterizer_running = 1'b0;
        pixel_in_pipeline = 1'b0;
        random_ready = 1'b0;
        repeat (4) @(posedge aclk);
        resetn <= 1'b1;
        @(posedge aclk);

        // Second triangle waits behind the rasterizer
        send_triangle(24);
        send_triangle(16);
        send_nop();
        wait_drained();
        assert (frame_starts == tri_cmds)
        else report_mismatch("start_rendering rises", tri_cmds, frame_starts);
        finish_test("triangle stream");

        send_texture(4, 1'b0);
        send_texture(3, 1'b1);
        send_texture(0, 1'b1);
        send_texture(0, 1'b0);
        send_nop();
        wait_drained();
        finish_test("texture streams");

        send_fog();
        send_nop();
        wait_drained();
        finish_test("fog table");

        send_render_config(4'd5);
        send_render_config(4'd12);
        send_nop();
        wait_drained();
        finish_test("render config");

        send_framebuffer(1'b1, 1'b0, 1'b1, 1'b1);
        send_framebuffer(1'b0, 1'b1, 1'b1, 1'b0);
        send_framebuffer(1'b1, 1'b1, 1'b0, 1'b1);
        send_nop();
        wait_drained();
        finish_test("framebuffer apply");

        random_ready <= 1'b1;
        send_triangle(32);
        send_texture(5, 1'b1);
        send_texture(4, 1'b0);
        send_fog();
        send_render_config(4'd9);
        send_texture(0, 1'b0);
        send_framebuffer(1'b0, 1'b0, 1'b1, 1'b1);
        send_nop();
        wait_drained();
        random_ready <= 1'b0;
        assert (frame_starts == tri_cmds)
        else report_mismatch("start_rendering rises", tri_cmds, frame_starts);
        finish_test("random back-pressure");

        $display("%0d tests run, %0d clean, %0d with errors, %0d errors in total",
                 tests_run, tests_run - tests_bad, tests_bad, error_count);
        if (error_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end
endmodule

`default_nettype wire

/* design/cmd_frontend_top.sv */
// Top level of the command front end, parser with output slices, render and buffer control
`default_nettype none

module cmd_frontend_top (
    input  logic                       aclk,
    input  logic                       resetn,
    input  logic                       s_cmd_valid,
    output logic                       s_cmd_ready,
    input  raster_cmd_pkg::axis_beat_t s_cmd_beat,
    output logic                       m_tri_valid,
    input  logic                       m_tri_ready,
    output raster_cmd_pkg::axis_beat_t m_tri_beat,
    output logic                       m_tex0_valid,
    input  logic                       m_tex0_ready,
    output raster_cmd_pkg::axis_beat_t m_tex0_beat,
    output logic                       m_tex1_valid,
    input  logic                       m_tex1_ready,
    output raster_cmd_pkg::axis_beat_t m_tex1_beat,
    output logic                       m_fog_valid,
    input  logic                       m_fog_ready,
    output raster_cmd_pkg::axis_beat_t m_fog_beat,
    output logic                       m_rcfg_valid,
    input  logic                       m_rcfg_ready,
    output raster_cmd_pkg::axis_beat_t m_rcfg_beat,
    input  logic                       rasterizer_running,
    input  logic                       pixel_in_pipeline,
    output logic                       start_rendering,
    input  logic                       color_applied,
    input  logic                       depth_applied,
    output logic                       color_apply,
    output logic                       depth_apply,
    output logic                       buffer_commit,
    output logic                       buffer_memset
);
    import raster_cmd_pkg::*;

    axis_beat_t tri_beat, tex0_beat, tex1_beat, fog_beat, rcfg_beat;
    logic       tri_valid, tex0_valid, tex1_valid, fog_valid, rcfg_valid;
    logic       tri_ready, tex0_ready, tex1_ready, fog_ready, rcfg_ready;
    logic       pipeline_idle, buffers_idle, frame_start, fb_req;
    fb_cmd_t    fb_cmd;

    cmd_parser i_parser (
        .aclk, .resetn,
        .cmd_valid(s_cmd_valid), .cmd_ready(s_cmd_ready), .cmd_beat(s_cmd_beat),
        .tri_valid, .tri_ready, .tri_beat,
        .tex0_valid, .tex0_ready, .tex0_beat,
        .tex1_valid, .tex1_ready, .tex1_beat,
        .fog_valid, .fog_ready, .fog_beat,
        .rcfg_valid, .rcfg_ready, .rcfg_beat,
        .pipeline_idle, .buffers_idle, .frame_start, .fb_req, .fb_cmd
    );

    axis_skid_buffer #(.beat_t(axis_beat_t)) i_tri_skid (
        .aclk, .resetn,
        .in_valid(tri_valid), .in_ready(tri_ready), .in_beat(tri_beat),
        .out_valid(m_tri_valid), .out_ready(m_tri_ready), .out_beat(m_tri_beat)
    );

    axis_skid_buffer #(.beat_t(axis_beat_t)) i_tex0_skid (
        .aclk, .resetn,
        .in_valid(tex0_valid), .in_ready(tex0_ready), .in_beat(tex0_beat),
        .out_valid(m_tex0_valid), .out_ready(m_tex0_ready), .out_beat(m_tex0_beat)
    );

    axis_skid_buffer #(.beat_t(axis_beat_t)) i_tex1_skid (
        .aclk, .resetn,
        .in_valid(tex1_valid), .in_ready(tex1_ready), .in_beat(tex1_beat),
        .out_valid(m_tex1_valid), .out_ready(m_tex1_ready), .out_beat(m_tex1_beat)
    );

    axis_skid_buffer #(.beat_t(axis_beat_t)) i_fog_skid (
        .aclk, .resetn,
        .in_valid(fog_valid), .in_ready(fog_ready), .in_beat(fog_beat),
        .out_valid(m_fog_valid), .out_ready(m_fog_ready), .out_beat(m_fog_beat)
    );

    axis_skid_buffer #(.beat_t(axis_beat_t)) i_rcfg_skid (
        .aclk, .resetn,
        .in_valid(rcfg_valid), .in_ready(rcfg_ready), .in_beat(rcfg_beat),
        .out_valid(m_rcfg_valid), .out_ready(m_rcfg_ready), .out_beat(m_rcfg_beat)
    );

    render_control i_render_control (
        .aclk, .resetn,
        .frame_start, .rasterizer_running, .pixel_in_pipeline,
        .start_rendering, .pipeline_idle
    );

    buffer_apply_ctrl i_buffer_apply_ctrl (
        .aclk, .resetn,
        .fb_req, .fb_cmd, .color_applied, .depth_applied,
        .color_apply, .depth_apply, .buffer_commit, .buffer_memset, .buffers_idle
    );

endmodule

`default_nettype wire

/* design/buffer_apply_ctrl.sv */
// Drives framebuffer apply, commit and memset strobes and tracks buffer completion
`default_nettype none

module buffer_apply_ctrl (
    input  logic                    aclk,
    input  logic                    resetn,
    input  logic                    fb_req,
    input  raster_cmd_pkg::fb_cmd_t fb_cmd,
    input  logic                    color_applied,
    input  logic                    depth_applied,
    output logic                    color_apply,
    output logic                    depth_apply,
    output logic                    buffer_commit,
    output logic                    buffer_memset,
    output logic                    buffers_idle
);
    typedef enum logic [1:0] {
        idle,
        wait_busy,
        wait_done
    } state_e;

    state_e state;
    logic   started;

    // A selected buffer has picked up the request
    assign started = (color_apply && !color_applied) || (depth_apply && !depth_applied);

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= idle;
            color_apply <= 1'b0;
            depth_apply <= 1'b0;
            buffer_commit <= 1'b0;
            buffer_memset <= 1'b0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (fb_req)
                    begin
                        color_apply <= fb_cmd.color_select;
                        depth_apply <= fb_cmd.depth_select;
                        buffer_commit <= fb_cmd.commit;
                        buffer_memset <= fb_cmd.memset;
                        if (fb_cmd.color_select || fb_cmd.depth_select)
                            state <= wait_busy;
                    end
                end
                wait_busy:
                begin
                    if (started)
                    begin
                        color_apply <= 1'b0;
                        depth_apply <= 1'b0;
                        state <= wait_done;
                    end
                end
                wait_done:
                begin
                    if (color_applied && depth_applied)
                        state <= idle;
                end
                default:
                    state <= idle;
            endcase
        end
    end

    assign buffers_idle = (state == idle) && color_applied && depth_applied;

    req_only_when_idle: assert property (
        @(posedge aclk) disable iff (!resetn) fb_req |-> buffers_idle);

endmodule

`default_nettype wire

/* design/render_control.sv */
// Holds the start-rendering request for the rasterizer and summarizes pipeline idleness
`default_nettype none

module render_control (
    input  logic aclk,
    input  logic resetn,
    input  logic frame_start,
    input  logic rasterizer_running,
    input  logic pixel_in_pipeline,
    output logic start_rendering,
    output logic pipeline_idle
);
    typedef enum logic {
        rc_idle,
        rc_request
    } state_e;

    state_e state;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
            state <= rc_idle;
        else
        begin
            case (state)
                rc_idle:
                begin
                    if (frame_start)
                        state <= rc_request;
                end
                rc_request:
                begin
                    // Rasterizer has taken the frame
                    if (rasterizer_running)
                        state <= rc_idle;
                end
                default:
                    state <= rc_idle;
            endcase
        end
    end

    assign start_rendering = (state == rc_request);
    assign pipeline_idle = !start_rendering && !rasterizer_running && !pixel_in_pipeline;

endmodule

`default_nettype wire

/* design/cmd_parser.sv */
// Command header decoder that routes counted payload beats to one of five output streams
`default_nettype none

module cmd_parser (
    input  logic                       aclk,
    input  logic                       resetn,
    input  logic                       cmd_valid,
    output logic                       cmd_ready,
    input  raster_cmd_pkg::axis_beat_t cmd_beat,
    output logic                       tri_valid,
    input  logic                       tri_ready,
    output raster_cmd_pkg::axis_beat_t tri_beat,
    output logic                       tex0_valid,
    input  logic                       tex0_ready,
    output raster_cmd_pkg::axis_beat_t tex0_beat,
    output logic                       tex1_valid,
    input  logic                       tex1_ready,
    output raster_cmd_pkg::axis_beat_t tex1_beat,
    output logic                       fog_valid,
    input  logic                       fog_ready,
    output raster_cmd_pkg::axis_beat_t fog_beat,
    output logic                       rcfg_valid,
    input  logic                       rcfg_ready,
    output raster_cmd_pkg::axis_beat_t rcfg_beat,
    input  logic                       pipeline_idle,
    input  logic                       buffers_idle,
    output logic                       frame_start,
    output logic                       fb_req,
    output raster_cmd_pkg::fb_cmd_t    fb_cmd
);
    import raster_cmd_pkg::*;

    typedef enum logic [2:0] {
        wait_idle,
        cmd_in,
        exec_tri,
        exec_tex0,
        exec_tex1,
        exec_fog,
        exec_rcfg
    } state_e;

    state_e                      state;
    state_e                      target;
    state_e                      hdr_target;
    cmd_op_e                     op;
    logic [tex_log2_width-1:0]   tex_log2;
    logic [beat_count_width-1:0] hdr_beats;
    logic [beat_count_width-1:0] count;
    logic [rc_index_width-1:0]   rc_index;
    axis_beat_t                  beat_in;
    axis_beat_t                  out_beat;
    axis_beat_t                  pend_beat;
    logic                        out_valid;
    logic                        pend_valid;
    logic                        sel_ready;
    logic                        out_take;
    logic                        pend_next;
    logic                        in_exec;
    logic                        cmd_fire;
    logic                        pay_fire;
    logic                        last_fire;

    assign op = cmd_op_e'(cmd_beat.tdata[op_pos +: op_width]);
    assign tex_log2 = cmd_beat.tdata[tex_log2_pos +: tex_log2_width];

    assign in_exec = (state != wait_idle) && (state != cmd_in);
    assign cmd_fire = cmd_valid && cmd_ready;
    assign pay_fire = cmd_fire && in_exec;
    assign last_fire = pay_fire && (count == beat_count_width'(1));

    // Unknown opcodes and empty payloads end up with zero beats
    always_comb
    begin
        hdr_beats = '0;
        hdr_target = wait_idle;
        case (op)
            op_triangle_stream:
            begin
                hdr_beats = beat_count_width'(cmd_beat.tdata[tri_size_pos +: tri_size_width] >> 2);
                hdr_target = exec_tri;
            end
            op_texture_stream:
            begin
                if (tex_log2 >= 5'd2)
                    hdr_beats = beat_count_width'(1) << (tex_log2 - 5'd2);
                hdr_target = cmd_beat.tdata[tex_tmu_pos] ? exec_tex1 : exec_tex0;
            end
            op_fog_lut_stream:
            begin
                hdr_beats = beat_count_width'(fog_lut_beats);
                hdr_target = exec_fog;
            end
            op_render_config:
            begin
                hdr_beats = beat_count_width'(1);
                hdr_target = exec_rcfg;
            end
            default:
            begin
            end
        endcase
    end

    always_comb
    begin
        case (target)
            exec_tri:  sel_ready = tri_ready;
            exec_tex0: sel_ready = tex0_ready;
            exec_tex1: sel_ready = tex1_ready;
            exec_fog:  sel_ready = fog_ready;
            exec_rcfg: sel_ready = rcfg_ready;
            default:   sel_ready = 1'b0;
        endcase
    end

    // Output register plus one pending slot covers the registered cmd_ready
    assign out_take = !out_valid || sel_ready;
    assign pend_next = !out_take && (pend_valid || pay_fire);
    assign beat_in = '{tdata: cmd_beat.tdata, tlast: count == beat_count_width'(1), tuser: rc_index};

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
            pend_valid <= 1'b0;
        end
        else
        begin
            pend_valid <= pend_next;
            if (out_take)
                out_valid <= pend_valid || pay_fire;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (out_take)
            out_beat <= pend_valid ? pend_beat : beat_in;
        else if (pay_fire)
            pend_beat <= beat_in;
    end

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            state <= wait_idle;
            target <= wait_idle;
            count <= '0;
            rc_index <= '0;
            cmd_ready <= 1'b0;
            frame_start <= 1'b0;
            fb_req <= 1'b0;
        end
        else
        begin
            frame_start <= 1'b0;
            fb_req <= 1'b0;
            case (state)
                wait_idle:
                begin
                    // Previous command fully handed off and its pulses seen downstream
                    if (pipeline_idle && buffers_idle && tri_ready && !out_valid
                        && !frame_start && !fb_req)
                    begin
                        cmd_ready <= 1'b1;
                        state <= cmd_in;
                    end
                end
                cmd_in:
                begin
                    if (cmd_fire)
                    begin
                        count <= hdr_beats;
                        target <= hdr_target;
                        rc_index <= (op == op_render_config) ?
                                    cmd_beat.tdata[rc_index_pos +: rc_index_width] : '0;
                        if (op == op_framebuffer)
                        begin
                            fb_req <= 1'b1;
                            fb_cmd.commit <= cmd_beat.tdata[fb_commit_pos];
                            fb_cmd.memset <= cmd_beat.tdata[fb_memset_pos];
                            fb_cmd.color_select <= cmd_beat.tdata[fb_color_pos];
                            fb_cmd.depth_select <= cmd_beat.tdata[fb_depth_pos];
                        end
                        if (hdr_beats == '0)
                        begin
                            cmd_ready <= 1'b0;
                            state <= wait_idle;
                        end
                        else
                            state <= hdr_target;
                    end
                end
                default:
                begin
                    if (pay_fire)
                        count <= count - beat_count_width'(1);
                    if (last_fire)
                    begin
                        cmd_ready <= 1'b0;
                        frame_start <= (state == exec_tri);
                        state <= wait_idle;
                    end
                    else
                        cmd_ready <= sel_ready && !pend_next;
                end
            endcase
        end
    end

    assign tri_valid = out_valid && (target == exec_tri);
    assign tex0_valid = out_valid && (target == exec_tex0);
    assign tex1_valid = out_valid && (target == exec_tex1);
    assign fog_valid = out_valid && (target == exec_fog);
    assign rcfg_valid = out_valid && (target == exec_rcfg);
    assign tri_beat = out_beat;
    assign tex0_beat = out_beat;
    assign tex1_beat = out_beat;
    assign fog_beat = out_beat;
    assign rcfg_beat = out_beat;

    count_nonzero_in_exec: assert property (
        @(posedge aclk) disable iff (!resetn) in_exec |-> count != '0);

    // A beat in flight stays on the one stream it was decoded for
    target_held_while_valid: assert property (
        @(posedge aclk) disable iff (!resetn) out_valid |-> $stable(target));

endmodule

`default_nettype wire

/* design/axis_skid_buffer.sv */
// Two-entry register slice that breaks the ready path of a valid/ready stream
`default_nettype none

module axis_skid_buffer #(
    parameter type beat_t = logic [31:0]
) (
    input  logic  aclk,
    input  logic  resetn,
    input  logic  in_valid,
    output logic  in_ready,
    input  beat_t in_beat,
    output logic  out_valid,
    input  logic  out_ready,
    output beat_t out_beat
);
    beat_t skid_beat;
    logic  skid_valid;
    logic  in_fire;
    logic  main_free;

    assign in_fire = in_valid && in_ready;
    assign main_free = !out_valid || out_ready;
    assign in_ready = !skid_valid;

    always_ff @(posedge aclk)
    begin
        if (!resetn)
        begin
            out_valid <= 1'b0;
            skid_valid <= 1'b0;
        end
        else if (main_free)
        begin
            out_valid <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end
        else if (in_fire)
            skid_valid <= 1'b1;
    end

    // Skid slot drains first so order is kept
    always_ff @(posedge aclk)
    begin
        if (main_free)
        begin
            if (skid_valid)
                out_beat <= skid_beat;
            else if (in_fire)
                out_beat <= in_beat;
        end
        else if (in_fire)
            skid_beat <= in_beat;
    end

    beat_stable_on_stall: assert property (
        @(posedge aclk) disable iff (!resetn)
        out_valid && !out_ready |=> $stable(out_beat));

endmodule

`default_nettype wire

/* design/raster_cmd_pkg.sv */
// Shared opcodes, header field positions and beat types for the rasterizer command front end
`default_nettype none

package raster_cmd_pkg;

    // Opcode field in the header word
    localparam int unsigned op_pos = 28;
    localparam int unsigned op_width = 4;

    // Triangle header, payload size in bytes
    localparam int unsigned tri_size_pos = 0;
    localparam int unsigned tri_size_width = 18;

    // Texture header
    localparam int unsigned tex_log2_pos = 0;
    localparam int unsigned tex_log2_width = 5;
    localparam int unsigned tex_tmu_pos = 8;

    // Render config header
    localparam int unsigned rc_index_pos = 0;
    localparam int unsigned rc_index_width = 4;

    // Framebuffer header flags
    localparam int unsigned fb_commit_pos = 4;
    localparam int unsigned fb_memset_pos = 5;
    localparam int unsigned fb_color_pos = 6;
    localparam int unsigned fb_depth_pos = 7;

    localparam int unsigned fog_lut_beats = 33;
    localparam int unsigned beat_count_width = 19;

    typedef enum logic [op_width-1:0] {
        op_nop             = 4'd0,
        op_triangle_stream = 4'd1,
        op_texture_stream  = 4'd2,
        op_fog_lut_stream  = 4'd3,
        op_render_config   = 4'd4,
        op_framebuffer     = 4'd5
    } cmd_op_e;

    typedef struct packed {
        logic [31:0] tdata;
        logic        tlast;
        logic [3:0]  tuser;
    } axis_beat_t;

    typedef struct packed {
        logic commit;
        logic memset;
        logic color_select;
        logic depth_select;
    } fb_cmd_t;

endpackage

`default_nettype wire
